// File: pic8259.f
+incdir+logic
logic/pic_cmd_pkg.sv
logic/pic_state_pkg.sv
logic/pic_cmd_if.sv
logic/irq_latch.sv
logic/pic_host_port.sv
logic/pic_core.sv
logic/pic_top.sv
dv/pic_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pic8259 testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f pic8259.f --top-module pic_tb \
   -o pic_sim --Mdir obj_dir > build.log 2>&1 \
   && ./obj_dir/pic_sim > sim.log 2>&1 \
   || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -qx "Test OK" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: dv/pic_tb.sv
`default_nettype none
`include "pic_config.svh"

module pic_tb;
   import pic_cmd_pkg::*;
   import pic_state_pkg::*;

   localparam int NUM_ROWS   = 22;
   localparam int SETTLE     = 6;
   localparam int MAX_CYCLES = NUM_ROWS * 20 + 50;

   typedef struct {
      pic_byte_t ir;
      pic_op_e   op;
      pic_byte_t wdata;
      pic_byte_t exp_rdata;
      logic      exp_int;
   } row_t;

   logic      clk;
   logic      rst_n;
   pic_byte_t ir;
   logic      host_req;
   pic_op_e   host_op;
   pic_byte_t host_wdata;
   logic      host_ack;
   pic_byte_t host_rdata;
   logic      int_out;

   row_t      rows [NUM_ROWS];
   int        row_cnt;
   int        err_cnt;
   int        check_cnt;
   int        cycle_cnt;
   hp_state_e hp_seen;

   // Reference model of the three registers
   pic_byte_t m_irr;
   pic_byte_t m_imr;
   pic_byte_t m_isr;

   pic_top dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .ir         (ir),
      .host_req   (host_req),
      .host_op    (host_op),
      .host_wdata (host_wdata),
      .host_ack   (host_ack),
      .host_rdata (host_rdata),
      .int_out    (int_out)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         hp_seen = dut_i.host_i.state;
         $display("timeout after %0d cycles, host port stuck in %s", cycle_cnt, hp_seen.name());
         $display("Test FAILED");
         $finish;
      end
   end

   // Index of the lowest set bit, -1 when empty
   function automatic int first_set(input pic_byte_t v);
      int idx;
      idx = 0;
      while (idx < `PIC_NUM_IRQ && !v[idx]) begin
         idx++;
      end
      if (idx == `PIC_NUM_IRQ) begin
         idx = -1;
      end
      return idx;
   endfunction

   // Fully nested rule
   function automatic logic int_expected(input pic_byte_t irr_v, input pic_byte_t imr_v,
                                         input pic_byte_t isr_v);
      int cand;
      int active;
      cand   = first_set(irr_v & ~imr_v);
      active = first_set(isr_v);
      return (cand >= 0) && (active < 0 || cand < active);
   endfunction

   function automatic logic returns_data(input pic_op_e op);
      return op inside {OP_READ_IMR, OP_READ_IRR, OP_READ_ISR, OP_INTA};
   endfunction

   // Appends a row and steps the model through it
   task automatic add_row(input pic_byte_t ir_v, input pic_op_e op_v, input pic_byte_t wdata_v);
      row_t r;
      int   cand;
      r.ir        = ir_v;
      r.op        = op_v;
      r.wdata     = wdata_v;
      r.exp_rdata = '0;
      // Level lines are latched long before the check
      m_irr       = m_irr | ir_v;
      r.exp_int   = int_expected(m_irr, m_imr, m_isr);
      case (op_v)
         OP_WRITE_IMR: m_imr = wdata_v;
         OP_READ_IMR:  r.exp_rdata = m_imr;
         OP_READ_IRR:  r.exp_rdata = m_irr;
         OP_READ_ISR:  r.exp_rdata = m_isr;
         OP_EOI: begin
            cand = first_set(m_isr);
            if (cand >= 0) begin
               m_isr[cand] = 1'b0;
            end
         end
         OP_INTA: begin
            cand = first_set(m_irr & ~m_imr);
            if (cand >= 0) begin
               r.exp_rdata  = {`PIC_VECTOR_BASE, 3'(cand)};
               m_isr[cand]  = 1'b1;
               m_irr[cand]  = 1'b0;
               // A line still high comes straight back
               m_irr        = m_irr | ir_v;
            end else begin
               r.exp_rdata = {`PIC_VECTOR_BASE, 3'd7};
            end
         end
         default: begin
         end
      endcase
      if (row_cnt < NUM_ROWS) begin
         rows[row_cnt] = r;
      end
      row_cnt++;
   endtask

   task automatic build_table();
      m_irr = '0;
      m_imr = '0;
      m_isr = '0;
      // Mask line 3, raise it, drop it
      add_row(8'h00, OP_WRITE_IMR, 8'h08);
      add_row(8'h08, OP_READ_IMR,  8'h00);
      add_row(8'h00, OP_READ_IRR,  8'h00);
      // Unmask, the latched request shows up
      add_row(8'h00, OP_WRITE_IMR, 8'h00);
      add_row(8'h00, OP_READ_IRR,  8'h00);
      // Lines 2 and 5 join, ack picks 2
      add_row(8'h24, OP_READ_IRR,  8'h00);
      add_row(8'h00, OP_INTA,      8'h00);
      add_row(8'h00, OP_READ_ISR,  8'h00);
      add_row(8'h00, OP_READ_IRR,  8'h00);
      // Line 1 nests over line 2
      add_row(8'h02, OP_READ_IRR,  8'h00);
      add_row(8'h00, OP_INTA,      8'h00);
      add_row(8'h00, OP_READ_ISR,  8'h00);
      add_row(8'h00, OP_EOI,       8'h00);
      add_row(8'h00, OP_READ_ISR,  8'h00);
      add_row(8'h00, OP_EOI,       8'h00);
      add_row(8'h00, OP_READ_ISR,  8'h00);
      // Drain lines 3 and 5
      add_row(8'h00, OP_INTA,      8'h00);
      add_row(8'h00, OP_EOI,       8'h00);
      add_row(8'h00, OP_INTA,      8'h00);
      add_row(8'h00, OP_EOI,       8'h00);
      // Spurious
      add_row(8'h00, OP_INTA,      8'h00);
      add_row(8'h00, OP_READ_ISR,  8'h00);
   endtask

   // Step to just after the next rising edge
   task automatic wait_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic run_handshake(input pic_op_e op, input pic_byte_t wdata);
      host_op    = op;
      host_wdata = wdata;
      host_req   = 1'b1;
      while (!host_ack) begin
         wait_cycle();
      end
      host_req = 1'b0;
   endtask

   task automatic finish_handshake();
      while (host_ack) begin
         wait_cycle();
      end
   endtask

   initial begin
      ir         = '0;
      host_req   = 1'b0;
      host_op    = OP_READ_IMR;
      host_wdata = '0;
      rst_n      = 1'b0;
      row_cnt    = 0;
      err_cnt    = 0;
      check_cnt  = 0;
      cycle_cnt  = 0;
      build_table();
      if (row_cnt != NUM_ROWS) begin
         $display("stimulus table holds %0d rows but room was made for %0d", row_cnt, NUM_ROWS);
         err_cnt++;
      end
      repeat (3) wait_cycle();
      rst_n = 1'b1;
      for (int r = 0; r < NUM_ROWS; r++) begin
         ir = rows[r].ir;
         repeat (SETTLE) wait_cycle();
         check_cnt++;
         assert (int_out === rows[r].exp_int) else begin
            err_cnt++;
            $display("error: time %0t row %0d int_out expected %0b got %0b",
                     $time, r, rows[r].exp_int, int_out);
         end
         run_handshake(rows[r].op, rows[r].wdata);
         // host_rdata is held until host_ack falls
         if (returns_data(rows[r].op)) begin
            check_cnt++;
            assert (host_rdata === rows[r].exp_rdata) else begin
               err_cnt++;
               $display("error: time %0t row %0d host_rdata expected %h got %h",
                        $time, r, rows[r].exp_rdata, host_rdata);
            end
         end
         finish_handshake();
      end
      $display("checks: %0d errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/pic_top.sv
`default_nettype none
`include "pic_config.svh"

module pic_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PIC_NUM_IRQ-1:0] ir,
   input  logic                    host_req,
   input  pic_cmd_pkg::pic_op_e    host_op,
   input  pic_cmd_pkg::pic_byte_t  host_wdata,
   output logic                    host_ack,
   output pic_cmd_pkg::pic_byte_t  host_rdata,
   output logic                    int_out
);

   // Request register and its clear from the core
   logic [`PIC_NUM_IRQ-1:0] irr;
   logic [`PIC_NUM_IRQ-1:0] irr_clear;

   // Host port to core command path
   pic_cmd_if cmd_if ();

   irq_latch latch_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .ir        (ir),
      .irr_clear (irr_clear),
      .irr       (irr)
   );

   pic_core core_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .irr       (irr),
      .irr_clear (irr_clear),
      .int_out   (int_out),
      .cmd       (cmd_if.core)
   );

   pic_host_port host_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .host_req   (host_req),
      .host_op    (host_op),
      .host_wdata (host_wdata),
      .host_ack   (host_ack),
      .host_rdata (host_rdata),
      .cmd        (cmd_if.host)
   );

endmodule

`default_nettype wire

// File: logic/pic_core.sv
`default_nettype none
`include "pic_config.svh"

module pic_core (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PIC_NUM_IRQ-1:0] irr,
   output logic [`PIC_NUM_IRQ-1:0] irr_clear,
   output logic                    int_out,
   pic_cmd_if.core                 cmd
);
   import pic_cmd_pkg::*;

   localparam int IDX_W = $clog2(`PIC_NUM_IRQ);

   logic [`PIC_NUM_IRQ-1:0] imr;
   logic [`PIC_NUM_IRQ-1:0] isr;
   logic [`PIC_NUM_IRQ-1:0] req_unmasked;
   logic [IDX_W-1:0]        cand_idx;
   logic                    cand_valid;
   logic [IDX_W-1:0]        isr_idx;
   logic                    isr_any;
   logic                    int_pending;

   // Lowest set bit, line 0 is highest priority
   // Empty vector gives the last index
   function automatic logic [IDX_W-1:0] low_idx(input logic [`PIC_NUM_IRQ-1:0] v);
      logic [IDX_W-1:0] idx;
      idx = IDX_W'(`PIC_NUM_IRQ - 1);
      for (int i = `PIC_NUM_IRQ - 1; i >= 0; i--) begin
         if (v[i]) begin
            idx = IDX_W'(i);
         end
      end
      return idx;
   endfunction

   // Priority resolution
   always_comb begin
      req_unmasked = irr & ~imr;
      cand_valid   = |req_unmasked;
      cand_idx     = low_idx(req_unmasked);
      isr_any      = |isr;
      isr_idx      = low_idx(isr);
      // Fully nested, only a strictly higher line interrupts
      int_pending  = cand_valid && (!isr_any || cand_idx < isr_idx);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         int_out <= 1'b0;
      end else begin
         int_out <= int_pending;
      end
   end

   // Register updates from host commands
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         imr          <= '0;
         isr          <= '0;
         irr_clear    <= '0;
         cmd.cmd_done <= 1'b0;
      end else begin
         irr_clear    <= '0;
         cmd.cmd_done <= cmd.cmd_valid;
         if (cmd.cmd_valid) begin
            case (cmd.cmd_op)
               OP_WRITE_IMR: begin
                  imr <= cmd.cmd_wdata;
               end
               OP_EOI: begin
                  // Non-specific, retire the highest in-service line
                  if (isr_any) begin
                     isr[isr_idx] <= 1'b0;
                  end
               end
               OP_INTA: begin
                  // No candidate means spurious, nothing changes
                  if (cand_valid) begin
                     isr[cand_idx]       <= 1'b1;
                     irr_clear[cand_idx] <= 1'b1;
                  end
               end
               default: begin
               end
            endcase
         end
      end
   end

   // Result byte, taken by the host port with cmd_done
   always_ff @(posedge clk) begin
      if (cmd.cmd_valid) begin
         case (cmd.cmd_op)
            OP_READ_IMR: cmd.cmd_rdata <= imr;
            OP_READ_IRR: cmd.cmd_rdata <= irr;
            OP_READ_ISR: cmd.cmd_rdata <= isr;
            // Spurious ack falls out as index 7
            OP_INTA:     cmd.cmd_rdata <= {`PIC_VECTOR_BASE, cand_idx};
            default:     cmd.cmd_rdata <= '0;
         endcase
      end
   end

   // In-service bits only appear through an acknowledge
   a_isr_from_inta: assert property (
      @(posedge clk) disable iff (!rst_n)
      |(isr & ~$past(isr)) |-> $past(cmd.cmd_valid && cmd.cmd_op == OP_INTA)
   ) else $error("pic_core: isr gained a bit without OP_INTA");

endmodule

`default_nettype wire

// File: logic/pic_host_port.sv
`default_nettype none

module pic_host_port (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   host_req,
   input  pic_cmd_pkg::pic_op_e   host_op,
   input  pic_cmd_pkg::pic_byte_t host_wdata,
   output logic                   host_ack,
   output pic_cmd_pkg::pic_byte_t host_rdata,
   pic_cmd_if.host                cmd
);
   import pic_state_pkg::*;

   hp_state_e state;

   // Handshake FSM, one command pulse per transaction
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= HP_IDLE;
         host_ack      <= 1'b0;
         cmd.cmd_valid <= 1'b0;
      end else begin
         cmd.cmd_valid <= 1'b0;
         case (state)
            HP_IDLE: begin
               if (host_req) begin
                  state         <= HP_EXEC;
                  cmd.cmd_valid <= 1'b1;
               end
            end
            HP_EXEC: begin
               // Core answers one cycle after the strobe
               if (cmd.cmd_done) begin
                  state    <= HP_ACK;
                  host_ack <= 1'b1;
               end
            end
            HP_ACK: begin
               if (!host_req) begin
                  state    <= HP_IDLE;
                  host_ack <= 1'b0;
               end
            end
            default: begin
               state    <= HP_IDLE;
               host_ack <= 1'b0;
            end
         endcase
      end
   end

   // Opcode and data are stable while host_req is high
   always_ff @(posedge clk) begin
      if (state == HP_IDLE && host_req) begin
         cmd.cmd_op    <= host_op;
         cmd.cmd_wdata <= host_wdata;
      end
   end

   // Read data held for the whole ack phase
   always_ff @(posedge clk) begin
      if (state == HP_EXEC && cmd.cmd_done) begin
         host_rdata <= cmd.cmd_rdata;
      end
   end

   // A new command only starts from idle
   a_valid_from_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(cmd.cmd_valid) |-> $past(state) == HP_IDLE
   ) else $error("pic_host_port: cmd_valid rose outside HP_IDLE");

   // Four-phase rule, ack drops only after req has dropped
   a_ack_after_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      $fell(host_ack) |-> !$past(host_req)
   ) else $error("pic_host_port: host_ack fell while host_req high");

endmodule

`default_nettype wire

// File: logic/irq_latch.sv
`default_nettype none
`include "pic_config.svh"

module irq_latch (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PIC_NUM_IRQ-1:0] ir,
   input  logic [`PIC_NUM_IRQ-1:0] irr_clear,
   output logic [`PIC_NUM_IRQ-1:0] irr
);

   // Synchronizer chain with stage 0 on the pins
   logic [`PIC_SYNC_STAGES-1:0][`PIC_NUM_IRQ-1:0] sync_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= ir;
         for (int i = 1; i < `PIC_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // Level request sets the bit and a clear from the core wins
   // A line still high sets it again on the following edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         irr <= '0;
      end else begin
         irr <= (irr | sync_q[`PIC_SYNC_STAGES-1]) & ~irr_clear;
      end
   end

   // Core clears at most one request per acknowledge
   a_clear_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(irr_clear)
   ) else $error("irq_latch: irr_clear has more than one bit set");

endmodule

`default_nettype wire

// File: logic/pic_cmd_if.sv
`default_nettype none

interface pic_cmd_if;
   import pic_cmd_pkg::*;

   // Single-cycle command strobe and its payload
   logic      cmd_valid;
   pic_op_e   cmd_op;
   pic_byte_t cmd_wdata;

   // Result, valid with cmd_done one cycle after cmd_valid
   pic_byte_t cmd_rdata;
   logic      cmd_done;

   modport host (
      output cmd_valid,
      output cmd_op,
      output cmd_wdata,
      input  cmd_rdata,
      input  cmd_done
   );

   modport core (
      input  cmd_valid,
      input  cmd_op,
      input  cmd_wdata,
      output cmd_rdata,
      output cmd_done
   );

endinterface

`default_nettype wire

// File: logic/pic_state_pkg.sv
`default_nettype none

package pic_state_pkg;

   // Host port handshake states
   typedef enum logic [1:0] {
      // Waiting for host_req
      HP_IDLE = 2'd0,
      // Command issued, waiting for the core
      HP_EXEC = 2'd1,
      // host_ack high until host_req drops
      HP_ACK  = 2'd2
   } hp_state_e;

endpackage

`default_nettype wire

// File: logic/pic_cmd_pkg.sv
`default_nettype none

package pic_cmd_pkg;

   // Host opcodes
   typedef enum logic [2:0] {
      // Load the mask register from the write data
      OP_WRITE_IMR = 3'd0,
      // Register reads
      OP_READ_IMR  = 3'd1,
      OP_READ_IRR  = 3'd2,
      OP_READ_ISR  = 3'd3,
      // Non-specific end of interrupt
      OP_EOI       = 3'd4,
      // Interrupt acknowledge, returns the vector
      OP_INTA      = 3'd5
   } pic_op_e;

   // Register values and vectors
   typedef logic [7:0] pic_byte_t;

endpackage

`default_nettype wire

// File: logic/pic_config.svh
`ifndef PIC_CONFIG_SVH
`define PIC_CONFIG_SVH

// Number of interrupt request lines
`define PIC_NUM_IRQ 8

// Upper five bits of every acknowledge vector
`define PIC_VECTOR_BASE 5'b00001

// Synchronizer flops on each request line
`define PIC_SYNC_STAGES 2

`endif
